//--- design/core_pkg.sv
package core_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN   = 32;                 // Data and PC width
    localparam int REG_AW = 5;                  // x0..x31
    localparam int CSR_AW = 12;

    // Machine CSR addresses
    localparam logic [CSR_AW-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_AW-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_AW-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_AW-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_AW-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_AW-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_AW-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_AW-1:0] CSR_MIP      = 12'h344;

    // Low two bits of funct3 for CSRRW/CSRRS/CSRRC
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // mcause exception codes with the interrupt flag kept apart
    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGN = 5'd0,
        EXC_ILLEGAL        = 5'd2,
        IRQ_SOFTWARE       = 5'd3,
        EXC_LOAD_MISALIGN  = 5'd4,
        EXC_STORE_MISALIGN = 5'd6,
        IRQ_TIMER          = 5'd7,
        IRQ_EXTERNAL       = 5'd11
    } trap_cause_e;

    // ----------------------------------------
    // MEM/WB pipeline word
    // ----------------------------------------
    typedef struct packed {
        logic valid;
        logic reg_write;
        logic mem_read;
        logic csr_read;
        logic csr_write;
        logic mret;
    } wb_ctrl_t;

    typedef struct packed {
        logic instr_misalign;
        logic illegal;
        logic load_misalign;
        logic store_misalign;
    } wb_exc_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   instruction;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   mem_address;     // Fault address for misaligned access
        logic [REG_AW-1:0] reg_id;
        csr_op_e           csr_op;
        logic [CSR_AW-1:0] csr_addr;
        logic [XLEN-1:0]   csr_wdata;
    } wb_data_t;

    // CSR view seen by trap control
    typedef struct packed {
        logic            mie_bit;            // mstatus.MIE
        logic            mpie_bit;           // mstatus.MPIE
        logic            mie_msie;
        logic            mie_mtie;
        logic            mie_meie;
        logic            mip_msip;
        logic            mip_mtip;
        logic            mip_meip;
        logic [29:0]     mtvec_base;
        logic [1:0]      mtvec_mode;
        logic [XLEN-1:0] mepc;
    } csr_state_t;

    // Trap and mret side effects on the CSRs
    typedef struct packed {
        trap_cause_e     cause;
        logic            is_irq;
        logic [XLEN-1:0] epc;
        logic [XLEN-1:0] tval;
        logic            mie_bit;
        logic            mpie_bit;
    } trap_update_t;

endpackage

//--- design/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                         clk,
    input  logic                         i_rst,
    // CSR instruction access
    input  logic                         i_csr_read,
    input  logic                         i_csr_write,
    input  core_pkg::csr_op_e            i_csr_op,
    input  logic [core_pkg::CSR_AW-1:0]  i_csr_addr,
    input  logic [core_pkg::XLEN-1:0]    i_csr_wdata,
    // Interrupt lines
    input  logic                         i_sw_irq,
    input  logic                         i_timer_irq,
    input  logic                         i_ext_irq,
    // From trap control
    input  logic                         i_trap_take,
    input  logic                         i_is_mret,
    input  core_pkg::trap_update_t       i_trap_upd,
    // Outputs
    output logic [core_pkg::XLEN-1:0]    o_csr_rdata,
    output core_pkg::csr_state_t         o_state
);

    // ----------------------------------------
    // CSR storage
    // ----------------------------------------
    logic                      mstatus_mie;
    logic                      mstatus_mpie;
    logic                      mie_msie;
    logic                      mie_mtie;
    logic                      mie_meie;
    logic                      mip_msip;
    logic                      mip_mtip;
    logic                      mip_meip;
    logic [29:0]               mtvec_base;
    logic                      mtvec_mode;  // 0 direct, 1 vectored
    logic [core_pkg::XLEN-1:0] mscratch;
    logic [core_pkg::XLEN-1:0] mepc;
    logic [core_pkg::XLEN-1:0] mcause;
    logic [core_pkg::XLEN-1:0] mtval;

    logic [core_pkg::XLEN-1:0] rd_val;      // Old value of addressed CSR
    logic [core_pkg::XLEN-1:0] csr_new;     // Value after read-modify-write

    // Read mux with MPP fixed at machine
    always_comb begin
        case (i_csr_addr)
            core_pkg::CSR_MSTATUS:  rd_val = {19'b0, 2'b11, 3'b0, mstatus_mpie,
                                              3'b0, mstatus_mie, 3'b0};
            core_pkg::CSR_MIE:      rd_val = {20'b0, mie_meie, 3'b0, mie_mtie,
                                              3'b0, mie_msie, 3'b0};
            core_pkg::CSR_MIP:      rd_val = {20'b0, mip_meip, 3'b0, mip_mtip,
                                              3'b0, mip_msip, 3'b0};
            core_pkg::CSR_MTVEC:    rd_val = {mtvec_base, 1'b0, mtvec_mode};
            core_pkg::CSR_MSCRATCH: rd_val = mscratch;
            core_pkg::CSR_MEPC:     rd_val = mepc;
            core_pkg::CSR_MCAUSE:   rd_val = mcause;
            core_pkg::CSR_MTVAL:    rd_val = mtval;
            default:                rd_val = '0;  // Unimplemented reads as zero
        endcase
    end

    assign o_csr_rdata = i_csr_read ? rd_val : '0;

    // Read-modify-write against old value
    always_comb begin
        case (i_csr_op)
            core_pkg::CSR_RW: csr_new = i_csr_wdata;
            core_pkg::CSR_RS: csr_new = rd_val | i_csr_wdata;
            core_pkg::CSR_RC: csr_new = rd_val & ~i_csr_wdata;
            default:          csr_new = rd_val;
        endcase
    end

    // ----------------------------------------
    // Register update
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_msie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_meie     <= 1'b0;
            mip_msip     <= 1'b0;
            mip_mtip     <= 1'b0;
            mip_meip     <= 1'b0;
            mtvec_base   <= '0;
            mtvec_mode   <= 1'b0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else begin
            // Interrupt lines sampled one cycle behind
            mip_msip <= i_sw_irq;
            mip_mtip <= i_timer_irq;
            mip_meip <= i_ext_irq;

            if (i_csr_write) begin
                case (i_csr_addr)
                    core_pkg::CSR_MSTATUS: begin
                        mstatus_mie  <= csr_new[3];
                        mstatus_mpie <= csr_new[7];
                    end
                    core_pkg::CSR_MIE: begin
                        mie_msie <= csr_new[3];
                        mie_mtie <= csr_new[7];
                        mie_meie <= csr_new[11];
                    end
                    core_pkg::CSR_MTVEC: begin
                        mtvec_base <= csr_new[31:2];
                        mtvec_mode <= csr_new[0];  // Direct or vectored only
                    end
                    core_pkg::CSR_MSCRATCH: mscratch <= csr_new;
                    core_pkg::CSR_MEPC:     mepc     <= {csr_new[31:2], 2'b00};
                    core_pkg::CSR_MCAUSE:   mcause   <= csr_new;
                    core_pkg::CSR_MTVAL:    mtval    <= csr_new;
                    default: ;              // mip and unknown ignored
                endcase
            end

            // Trap side effects written last so they win
            if (i_trap_take && !i_is_mret) begin
                mepc         <= i_trap_upd.epc;
                mcause       <= {i_trap_upd.is_irq, 26'b0, i_trap_upd.cause};
                mtval        <= i_trap_upd.tval;
                mstatus_mie  <= i_trap_upd.mie_bit;
                mstatus_mpie <= i_trap_upd.mpie_bit;
            end else if (i_is_mret) begin
                mstatus_mie  <= i_trap_upd.mie_bit;   // MIE from MPIE
                mstatus_mpie <= i_trap_upd.mpie_bit;
            end
        end
    end

    assign o_state = '{mie_bit: mstatus_mie, mpie_bit: mstatus_mpie,
                       mie_msie: mie_msie, mie_mtie: mie_mtie, mie_meie: mie_meie,
                       mip_msip: mip_msip, mip_mtip: mip_mtip, mip_meip: mip_meip,
                       mtvec_base: mtvec_base, mtvec_mode: {1'b0, mtvec_mode},
                       mepc: mepc};

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        i_rst,
    // Write port from write-back
    input  logic                        i_we,
    input  logic [core_pkg::REG_AW-1:0] i_waddr,
    input  logic [core_pkg::XLEN-1:0]   i_wdata,
    // Asynchronous read port
    input  logic [core_pkg::REG_AW-1:0] i_raddr,
    output logic [core_pkg::XLEN-1:0]   o_rdata
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    logic [core_pkg::XLEN-1:0] regs [2**core_pkg::REG_AW];   // Contents not reset

    always_ff @(posedge clk) begin
        // No writes during reset or to x0
        if (i_we && !i_rst && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // x0 reads as zero
    assign o_rdata = (i_raddr == '0) ? '0 : regs[i_raddr];

endmodule

//--- design/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
    input  core_pkg::wb_ctrl_t          i_ctrl,
    input  core_pkg::wb_exc_t           i_exc,
    input  core_pkg::wb_data_t          i_data,
    input  logic                        i_flush,
    input  core_pkg::csr_state_t        i_state,
    output logic                        o_trap_take,
    output logic [core_pkg::XLEN-1:0]   o_trap_pc,
    output logic                        o_is_mret,
    output core_pkg::trap_update_t      o_trap_upd
);

    logic                      active;       // Live instruction this cycle
    logic                      irq_ext;
    logic                      irq_sw;
    logic                      irq_timer;
    logic                      irq_take;
    logic                      exc_take;
    logic                      mret_take;
    core_pkg::trap_cause_e     cause;
    logic [core_pkg::XLEN-1:0] tval;
    logic [core_pkg::XLEN-1:0] vec_base;

    assign active = i_ctrl.valid & ~i_flush;

    // ----------------------------------------
    // Trap decision
    // ----------------------------------------
    // Enabled and pending and gated by global MIE
    assign irq_ext   = i_state.mie_bit & i_state.mie_meie & i_state.mip_meip;
    assign irq_sw    = i_state.mie_bit & i_state.mie_msie & i_state.mip_msip;
    assign irq_timer = i_state.mie_bit & i_state.mie_mtie & i_state.mip_mtip;

    assign irq_take  = active & (irq_ext | irq_sw | irq_timer);
    assign exc_take  = active & ~irq_take &
                       (i_exc.instr_misalign | i_exc.illegal |
                        i_exc.load_misalign | i_exc.store_misalign);
    assign mret_take = active & i_ctrl.mret & ~irq_take & ~exc_take;

    // Cause and trap value by priority
    always_comb begin
        cause = core_pkg::EXC_INSTR_MISALIGN;
        tval  = '0;                           // Interrupts report zero
        if (irq_ext) begin
            cause = core_pkg::IRQ_EXTERNAL;
        end else if (irq_sw) begin
            cause = core_pkg::IRQ_SOFTWARE;
        end else if (irq_timer) begin
            cause = core_pkg::IRQ_TIMER;
        end else if (i_exc.instr_misalign) begin
            cause = core_pkg::EXC_INSTR_MISALIGN;
            tval  = i_data.pc;
        end else if (i_exc.illegal) begin
            cause = core_pkg::EXC_ILLEGAL;
            tval  = i_data.instruction;       // Faulting encoding
        end else if (i_exc.load_misalign) begin
            cause = core_pkg::EXC_LOAD_MISALIGN;
            tval  = i_data.mem_address;
        end else if (i_exc.store_misalign) begin
            cause = core_pkg::EXC_STORE_MISALIGN;
            tval  = i_data.mem_address;
        end
    end

    // ----------------------------------------
    // Target PC
    // ----------------------------------------
    assign vec_base = {i_state.mtvec_base, 2'b00};

    always_comb begin
        if (mret_take) begin
            o_trap_pc = i_state.mepc;
        end else if (irq_take && i_state.mtvec_mode == 2'd1) begin
            o_trap_pc = vec_base + {25'b0, cause, 2'b00};   // base + 4*cause
        end else begin
            o_trap_pc = vec_base;
        end
    end

    assign o_trap_take = irq_take | exc_take | mret_take;  // Any redirect
    assign o_is_mret   = mret_take;

    // mstatus stack pushed on trap and popped on mret
    always_comb begin
        o_trap_upd.cause  = cause;
        o_trap_upd.is_irq = irq_take;
        o_trap_upd.epc    = i_data.pc;
        o_trap_upd.tval   = tval;
        if (mret_take) begin
            o_trap_upd.mie_bit  = i_state.mpie_bit;
            o_trap_upd.mpie_bit = 1'b1;
        end else begin
            o_trap_upd.mie_bit  = 1'b0;
            o_trap_upd.mpie_bit = i_state.mie_bit;
        end
    end

endmodule

//--- design/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_flush,
    // Interrupts
    input  logic                        i_sw_irq,
    input  logic                        i_timer_irq,
    input  logic                        i_ext_irq,
    // MEM/WB pipeline word
    input  core_pkg::wb_ctrl_t          i_ctrl,
    input  core_pkg::wb_exc_t           i_exc,
    input  core_pkg::wb_data_t          i_data,
    input  logic [core_pkg::XLEN-1:0]   i_mem_rdata,
    // To register file
    output logic                        o_reg_we,
    output logic [core_pkg::REG_AW-1:0] o_reg_id,
    output logic [core_pkg::XLEN-1:0]   o_reg_wdata,
    // To fetch
    output logic                        o_trap_take,
    output logic [core_pkg::XLEN-1:0]   o_trap_pc
);

    logic                      commit;       // Retires without trap or flush
    logic                      csr_read;
    logic                      csr_write;
    logic [core_pkg::XLEN-1:0] csr_rdata;
    logic                      is_mret;
    core_pkg::csr_state_t      csr_state;
    core_pkg::trap_update_t    trap_upd;

    // ----------------------------------------
    // Result select and gating
    // ----------------------------------------
    assign commit    = i_ctrl.valid & ~i_flush & ~o_trap_take;  // mret included
    assign csr_read  = i_ctrl.csr_read & commit;
    assign csr_write = i_ctrl.csr_write & commit;

    assign o_reg_we    = i_ctrl.reg_write & commit;
    assign o_reg_id    = i_data.reg_id;
    assign o_reg_wdata = i_ctrl.csr_read ? csr_rdata   :
                         i_ctrl.mem_read ? i_mem_rdata : i_data.alu_result;

    csr_file u_csr_file (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_csr_read  (csr_read),
        .i_csr_write (csr_write),
        .i_csr_op    (i_data.csr_op),
        .i_csr_addr  (i_data.csr_addr),
        .i_csr_wdata (i_data.csr_wdata),
        .i_sw_irq    (i_sw_irq),
        .i_timer_irq (i_timer_irq),
        .i_ext_irq   (i_ext_irq),
        .i_trap_take (o_trap_take),
        .i_is_mret   (is_mret),
        .i_trap_upd  (trap_upd),
        .o_csr_rdata (csr_rdata),
        .o_state     (csr_state)
    );

    trap_ctrl u_trap_ctrl (
        .i_ctrl      (i_ctrl),
        .i_exc       (i_exc),
        .i_data      (i_data),
        .i_flush     (i_flush),
        .i_state     (csr_state),
        .o_trap_take (o_trap_take),
        .o_trap_pc   (o_trap_pc),
        .o_is_mret   (is_mret),
        .o_trap_upd  (trap_upd)
    );

endmodule

//--- design/wb_top.sv
`timescale 1ns/1ps

module wb_top (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_flush,
    input  logic                        i_sw_irq,
    input  logic                        i_timer_irq,
    input  logic                        i_ext_irq,
    input  core_pkg::wb_ctrl_t          i_ctrl,
    input  core_pkg::wb_exc_t           i_exc,
    input  core_pkg::wb_data_t          i_data,
    input  logic [core_pkg::XLEN-1:0]   i_mem_rdata,
    input  logic [core_pkg::REG_AW-1:0] i_rd_addr,    // Debug read port
    output logic [core_pkg::XLEN-1:0]   o_rd_data,
    output logic                        o_trap_take,
    output logic [core_pkg::XLEN-1:0]   o_trap_pc
);

    logic                        reg_we;
    logic [core_pkg::REG_AW-1:0] reg_id;
    logic [core_pkg::XLEN-1:0]   reg_wdata;

    wb_stage u_wb_stage (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_flush     (i_flush),
        .i_sw_irq    (i_sw_irq),
        .i_timer_irq (i_timer_irq),
        .i_ext_irq   (i_ext_irq),
        .i_ctrl      (i_ctrl),
        .i_exc       (i_exc),
        .i_data      (i_data),
        .i_mem_rdata (i_mem_rdata),
        .o_reg_we    (reg_we),
        .o_reg_id    (reg_id),
        .o_reg_wdata (reg_wdata),
        .o_trap_take (o_trap_take),
        .o_trap_pc   (o_trap_pc)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_we    (reg_we),
        .i_waddr (reg_id),
        .i_wdata (reg_wdata),
        .i_raddr (i_rd_addr),
        .o_rdata (o_rd_data)
    );

endmodule

//--- dv/tb_wb_top.sv
`timescale 1ns/1ps

module tb_wb_top;

    // One table row per instruction slot
    typedef struct packed {
        core_pkg::wb_ctrl_t ctrl;
        core_pkg::wb_exc_t  exc;
        core_pkg::wb_data_t data;
        logic [31:0]        rdata;          // Load data
        logic [2:0]         irq;            // {ext, timer, sw}
        logic               flush;
        logic               exp_take;
        logic [31:0]        exp_pc;
        logic               chk_en;         // Check rd one cycle later
        logic [4:0]         chk_reg;
        logic [31:0]        chk_val;
        logic [2:0]         test;
    } row_t;

    logic clk, i_rst, i_flush, i_sw_irq, i_timer_irq, i_ext_irq;
    core_pkg::wb_ctrl_t i_ctrl;
    core_pkg::wb_exc_t  i_exc;
    core_pkg::wb_data_t i_data;
    logic [31:0] i_mem_rdata, o_rd_data, o_trap_pc;
    logic [4:0]  i_rd_addr;
    logic        o_trap_take;

    row_t        tbl [0:63];
    int          n_rows = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_errs [0:5];
    string       test_names [0:5] = '{"result select", "flush", "csr access",
                                      "exceptions", "mret", "interrupts"};
    logic        built = 1'b0;
    logic [31:0] seed = 32'h3d6be384;
    logic [2:0]  cur_irq = '0;              // Lines held for the rows being added
    logic        cur_flush = 1'b0;
    logic [2:0]  cur_test = '0;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    logic        st_mie, st_mpie, en_msie, en_mtie, en_meie;
    logic [2:0]  pend;                       // mip lags the lines by one row
    logic [29:0] tvec_base;
    logic        tvec_mode;
    logic [31:0] scratch, epc, cause_r, tval_r;
    logic [31:0] regs_ref [0:31];
    logic        known [0:31];               // Register written since start

    wb_top dut (
        .clk(clk), .i_rst(i_rst), .i_flush(i_flush), .i_sw_irq(i_sw_irq),
        .i_timer_irq(i_timer_irq), .i_ext_irq(i_ext_irq), .i_ctrl(i_ctrl),
        .i_exc(i_exc), .i_data(i_data), .i_mem_rdata(i_mem_rdata),
        .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
        .o_trap_take(o_trap_take), .o_trap_pc(o_trap_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                // 10 ns period
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Architectural read value of a CSR in the model
    function automatic logic [31:0] csr_value(input logic [11:0] a);
        case (a)
            core_pkg::CSR_MSTATUS:  return {19'b0, 2'b11, 3'b0, st_mpie, 3'b0, st_mie, 3'b0};
            core_pkg::CSR_MIE:      return {20'b0, en_meie, 3'b0, en_mtie, 3'b0, en_msie, 3'b0};
            core_pkg::CSR_MIP:      return {20'b0, pend[2], 3'b0, pend[1], 3'b0, pend[0], 3'b0};
            core_pkg::CSR_MTVEC:    return {tvec_base, 1'b0, tvec_mode};
            core_pkg::CSR_MSCRATCH: return scratch;
            core_pkg::CSR_MEPC:     return epc;
            core_pkg::CSR_MCAUSE:   return cause_r;
            core_pkg::CSR_MTVAL:    return tval_r;
            default:                return 32'h0;
        endcase
    endfunction

    function automatic core_pkg::wb_data_t fresh_data(input logic [4:0] rd);
        core_pkg::wb_data_t d;
        d             = '0;
        d.pc          = lcg_next() & 32'hFFFF_FFFC;   // Word aligned
        d.instruction = lcg_next();
        d.alu_result  = lcg_next();
        d.mem_address = lcg_next();
        d.reg_id      = rd;
        return d;
    endfunction

    // Steps the model by one slot and stores the row with its expectations
    task automatic add_row(input core_pkg::wb_ctrl_t c, input core_pkg::wb_exc_t e,
                           input core_pkg::wb_data_t d, input logic [31:0] ld);
        logic        active, irq_on, exc_on, mret_on, commit;
        logic [4:0]  cause;
        logic [31:0] tval, old, nv;
        row_t        r;
        active = c.valid && !cur_flush;
        irq_on = 1'b0;
        exc_on = 1'b0;
        cause  = 5'd0;
        tval   = 32'h0;
        // External, software, then timer interrupts first
        if (st_mie && en_meie && pend[2]) begin
            irq_on = active;
            cause  = 5'd11;
        end else if (st_mie && en_msie && pend[0]) begin
            irq_on = active;
            cause  = 5'd3;
        end else if (st_mie && en_mtie && pend[1]) begin
            irq_on = active;
            cause  = 5'd7;
        end else if (e.instr_misalign) begin
            exc_on = active;
            cause  = 5'd0;
            tval   = d.pc;
        end else if (e.illegal) begin
            exc_on = active;
            cause  = 5'd2;
            tval   = d.instruction;
        end else if (e.load_misalign) begin
            exc_on = active;
            cause  = 5'd4;
            tval   = d.mem_address;
        end else if (e.store_misalign) begin
            exc_on = active;
            cause  = 5'd6;
            tval   = d.mem_address;
        end
        mret_on = active && c.mret && !irq_on && !exc_on;
        commit  = active && !irq_on && !exc_on && !mret_on;
        r       = '0;
        r.ctrl  = c;
        r.exc   = e;
        r.data  = d;
        r.rdata = ld;
        r.irq   = cur_irq;
        r.flush = cur_flush;
        r.test  = cur_test;
        r.exp_take = irq_on || exc_on || mret_on;
        if (mret_on) r.exp_pc = epc;
        else if (irq_on && tvec_mode) r.exp_pc = {tvec_base, 2'b00} + 32'(cause) * 4;
        else r.exp_pc = {tvec_base, 2'b00};
        old = csr_value(d.csr_addr);          // Read sees pre-write value
        if (commit && c.reg_write && d.reg_id != 5'd0) begin
            regs_ref[d.reg_id] = c.csr_read ? old : (c.mem_read ? ld : d.alu_result);
            known[d.reg_id]    = 1'b1;
        end
        if (commit && c.csr_write) begin
            case (d.csr_op)
                core_pkg::CSR_RW: nv = d.csr_wdata;
                core_pkg::CSR_RS: nv = old | d.csr_wdata;
                default:          nv = old & ~d.csr_wdata;
            endcase
            case (d.csr_addr)
                core_pkg::CSR_MSTATUS: begin
                    st_mie  = nv[3];
                    st_mpie = nv[7];
                end
                core_pkg::CSR_MIE: begin
                    en_msie = nv[3];
                    en_mtie = nv[7];
                    en_meie = nv[11];
                end
                core_pkg::CSR_MTVEC: begin
                    tvec_base = nv[31:2];
                    tvec_mode = nv[0];
                end
                core_pkg::CSR_MSCRATCH: scratch = nv;
                core_pkg::CSR_MEPC:     epc = nv & 32'hFFFF_FFFC;
                core_pkg::CSR_MCAUSE:   cause_r = nv;
                core_pkg::CSR_MTVAL:    tval_r = nv;
                default: ;                    // mip is read-only
            endcase
        end
        if (irq_on || exc_on) begin
            epc     = d.pc;
            cause_r = {irq_on, 26'b0, cause};
            tval_r  = tval;                   // Zero for interrupts
            st_mpie = st_mie;
            st_mie  = 1'b0;
        end else if (mret_on) begin
            st_mie  = st_mpie;
            st_mpie = 1'b1;
        end
        pend      = cur_irq;
        r.chk_reg = d.reg_id;
        r.chk_en  = (d.reg_id == 5'd0) || known[d.reg_id];
        r.chk_val = (d.reg_id == 5'd0) ? 32'h0 : regs_ref[d.reg_id];
        tbl[n_rows] = r;
        n_rows++;
    endtask

    // ----------------------------------------
    // Instruction builders
    // ----------------------------------------
    task automatic alu_instr(input logic [4:0] rd, input logic mem);
        core_pkg::wb_ctrl_t c;
        c           = '0;
        c.valid     = 1'b1;
        c.reg_write = 1'b1;
        c.mem_read  = mem;
        add_row(c, '0, fresh_data(rd), lcg_next());
    endtask

    task automatic csr_instr(input logic [4:0] rd, input core_pkg::csr_op_e op,
                             input logic [11:0] addr, input logic [31:0] wdata);
        core_pkg::wb_ctrl_t c;
        core_pkg::wb_data_t d;
        c           = '0;
        c.valid     = 1'b1;
        c.reg_write = 1'b1;
        c.csr_read  = 1'b1;
        c.csr_write = 1'b1;
        d           = fresh_data(rd);
        d.csr_op    = op;
        d.csr_addr  = addr;
        d.csr_wdata = wdata;
        add_row(c, '0, d, lcg_next());
    endtask

    task automatic fault_instr(input logic [3:0] flags, input logic [4:0] rd);
        core_pkg::wb_ctrl_t c;
        core_pkg::wb_exc_t  e;
        c           = '0;
        c.valid     = 1'b1;
        c.reg_write = 1'b1;
        c.mem_read  = flags[1];
        e           = flags;                  // {instr, illegal, load, store}
        add_row(c, e, fresh_data(rd), lcg_next());
    endtask

    task automatic mret_instr(input logic [4:0] rd);
        core_pkg::wb_ctrl_t c;
        c           = '0;
        c.valid     = 1'b1;
        c.mret      = 1'b1;
        c.reg_write = 1'b1;                   // Write must be dropped
        add_row(c, '0, fresh_data(rd), lcg_next());
    endtask

    task automatic build_table();
        int k;
        st_mie    = 0;
        st_mpie   = 0;
        en_msie   = 0;
        en_mtie   = 0;
        en_meie   = 0;
        pend      = '0;
        tvec_base = '0;
        tvec_mode = 0;
        scratch   = '0;
        epc       = '0;
        cause_r   = '0;
        tval_r    = '0;
        for (k = 0; k < 32; k++) known[k] = 1'b0;
        cur_test = 0;                         // Result selection
        alu_instr(5'd1, 0);
        alu_instr(5'd2, 0);
        alu_instr(5'd3, 1);
        alu_instr(5'd4, 1);
        alu_instr(5'd0, 0);                   // x0 stays zero
        csr_instr(5'd5, core_pkg::CSR_RS, core_pkg::CSR_MSCRATCH, 32'h0);
        cur_test  = 1;
        cur_flush = 1'b1;
        alu_instr(5'd1, 0);
        fault_instr(4'b0100, 5'd2);           // Flag ignored under flush
        csr_instr(5'd3, core_pkg::CSR_RW, core_pkg::CSR_MSCRATCH, 32'h1234);
        cur_flush = 1'b0;
        csr_instr(5'd6, core_pkg::CSR_RS, core_pkg::CSR_MSCRATCH, 32'h0);
        cur_test = 2;
        csr_instr(5'd7, core_pkg::CSR_RW, core_pkg::CSR_MSCRATCH, 32'hA5A5_0F0F);
        csr_instr(5'd8, core_pkg::CSR_RS, core_pkg::CSR_MSCRATCH, 32'h0000_F0F0);
        csr_instr(5'd9, core_pkg::CSR_RC, core_pkg::CSR_MSCRATCH, 32'hA5A5_0000);
        csr_instr(5'd10, core_pkg::CSR_RS, core_pkg::CSR_MSCRATCH, 32'h0);
        csr_instr(5'd11, core_pkg::CSR_RW, core_pkg::CSR_MTVEC, 32'h0000_1000);
        csr_instr(5'd12, core_pkg::CSR_RS, core_pkg::CSR_MTVEC, 32'h1);
        csr_instr(5'd13, core_pkg::CSR_RC, core_pkg::CSR_MTVEC, 32'h1);
        csr_instr(5'd14, core_pkg::CSR_RS, core_pkg::CSR_MTVEC, 32'h0);
        cur_test = 3;                         // Each flag then its trap CSRs read back
        for (k = 0; k < 4; k++) begin
            fault_instr(4'b1000 >> k, 5'd1);
            csr_instr(5'd15, core_pkg::CSR_RS, core_pkg::CSR_MEPC, 32'h0);
            csr_instr(5'd16, core_pkg::CSR_RS, core_pkg::CSR_MCAUSE, 32'h0);
            csr_instr(5'd17, core_pkg::CSR_RS, core_pkg::CSR_MTVAL, 32'h0);
        end
        cur_test = 4;
        csr_instr(5'd18, core_pkg::CSR_RW, core_pkg::CSR_MSTATUS, 32'h80);  // MPIE only
        mret_instr(5'd1);
        csr_instr(5'd20, core_pkg::CSR_RS, core_pkg::CSR_MSTATUS, 32'h0);
        cur_test = 5;
        cur_irq  = 3'b010;                    // Timer line up
        alu_instr(5'd21, 0);
        alu_instr(5'd22, 0);                  // Pending with enable off
        csr_instr(5'd18, core_pkg::CSR_RC, core_pkg::CSR_MSTATUS, 32'h8);
        csr_instr(5'd19, core_pkg::CSR_RW, core_pkg::CSR_MIE, 32'h888);
        alu_instr(5'd23, 0);                  // Global MIE off
        csr_instr(5'd9, core_pkg::CSR_RW, core_pkg::CSR_MTVEC, 32'h0000_2001);
        csr_instr(5'd24, core_pkg::CSR_RS, core_pkg::CSR_MSTATUS, 32'h8);
        alu_instr(5'd25, 0);                  // Vectored timer trap
        cur_irq = 3'b000;
        csr_instr(5'd26, core_pkg::CSR_RS, core_pkg::CSR_MCAUSE, 32'h0);
        cur_irq = 3'b100;
        csr_instr(5'd27, core_pkg::CSR_RS, core_pkg::CSR_MSTATUS, 32'h8);
        fault_instr(4'b0100, 5'd28);          // External beats illegal
        cur_irq = 3'b000;
        csr_instr(5'd29, core_pkg::CSR_RS, core_pkg::CSR_MCAUSE, 32'h0);
        csr_instr(5'd30, core_pkg::CSR_RS, core_pkg::CSR_MTVAL, 32'h0);
        cur_irq = 3'b001;
        mret_instr(5'd0);
        alu_instr(5'd31, 0);                  // Software trap
        cur_irq = 3'b000;
        csr_instr(5'd2, core_pkg::CSR_RS, core_pkg::CSR_MCAUSE, 32'h0);
    endtask

    // ----------------------------------------
    // Stimulus and checks
    // ----------------------------------------
    initial begin
        row_t r;
        i_rst       = 1'b1;
        i_flush     = 1'b0;
        i_sw_irq    = 1'b0;
        i_timer_irq = 1'b0;
        i_ext_irq   = 1'b0;
        i_ctrl      = '0;
        i_exc       = '0;
        i_data      = '0;
        i_mem_rdata = '0;
        i_rd_addr   = '0;
        for (int t = 0; t < 6; t++) test_errs[t] = 0;
        build_table();
        built = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;
        for (int i = 0; i <= n_rows; i++) begin
            @(negedge clk);
            r = (i < n_rows) ? tbl[i] : '0;   // Trailing idle slot
            i_ctrl      = r.ctrl;
            i_exc       = r.exc;
            i_data      = r.data;
            i_mem_rdata = r.rdata;
            {i_ext_irq, i_timer_irq, i_sw_irq} = r.irq;
            i_flush = r.flush;
            if (i > 0) i_rd_addr = tbl[i-1].chk_reg;
            #1;
            if (i < n_rows) begin
                n_checks++;
                if (o_trap_take !== r.exp_take) begin
                    $display("[FAIL] row %0d o_trap_take exp %h got %h",
                             i, r.exp_take, o_trap_take);
                    n_errors++;
                    test_errs[r.test]++;
                end
                if (r.exp_take && o_trap_pc !== r.exp_pc) begin
                    $display("[FAIL] row %0d o_trap_pc exp %h got %h",
                             i, r.exp_pc, o_trap_pc);
                    n_errors++;
                    test_errs[r.test]++;
                end
            end
            if (i > 0 && tbl[i-1].chk_en) begin  // Previous row's rd now visible
                n_checks++;
                if (o_rd_data !== tbl[i-1].chk_val) begin
                    $display("[FAIL] row %0d x%0d o_rd_data exp %h got %h", i - 1,
                             tbl[i-1].chk_reg, tbl[i-1].chk_val, o_rd_data);
                    n_errors++;
                    test_errs[tbl[i-1].test]++;
                end
            end
            if (i > 0 && (i == n_rows || tbl[i].test != tbl[i-1].test))
                $display("test %s : %0d errors", test_names[tbl[i-1].test],
                         test_errs[tbl[i-1].test]);
        end
        $display("rows %0d, checks %0d, errors %0d", n_rows, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog scaled to table length
    initial begin
        wait (built);
        repeat (n_rows * 4 + 200) @(posedge clk);
        $display("Run did not finish within %0d cycles", n_rows * 4 + 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb.f
design/core_pkg.sv
design/csr_file.sv
design/trap_ctrl.sv
design/wb_stage.sv
design/reg_file.sv
design/wb_top.sv
dv/tb_wb_top.sv
